// File: source/map_pkg.sv
/* screen geometry, obstacle ranges, game mode encoding and the
   packed structs shared by the obstacle map blocks */
`default_nettype none

package map_pkg;

    // ============================================================
    // screen geometry
    // ============================================================
    localparam int screen_width = 640;
    localparam int upper_bound  = 20;
    localparam int lower_bound  = 460;
    localparam int scroll_speed = 4;

    // ============================================================
    // obstacle ranges
    // ============================================================
    localparam int min_width  = 20;
    localparam int max_width  = 80;
    localparam int min_height = 20;
    localparam int max_height = 150;
    localparam int min_gap    = 80;
    localparam int max_gap    = 180;

    // right edge below this means the obstacle is gone for good
    localparam int delete_margin = -100;

    // box coordinates for slots that are not on screen
    localparam int offscreen_x = 700;
    localparam int offscreen_y = 500;

    // spawn counter start value after idle
    localparam int spawn_reload = screen_width + min_gap;

    // 2 and 3 are both pause
    typedef enum logic [1:0] {
        mode_idle = 2'd0,
        mode_run  = 2'd1
    } game_mode_t;

    typedef struct packed {
        logic [6:0] width;
        logic [7:0] height;
        logic [8:0] y;
        logic [7:0] gap;
    } obstacle_shape_t;

    typedef struct packed {
        logic               active;
        logic signed [11:0] x;
        logic        [8:0]  y;
        logic        [6:0]  width;
        logic        [7:0]  height;
    } obstacle_t;

    typedef struct packed {
        logic [9:0] x_left;
        logic [9:0] x_right;
        logic [8:0] y_up;
        logic [8:0] y_down;
    } screen_box_t;

endpackage

`default_nettype wire

// File: source/obstacle_generator.sv
/* Galois LFSR and the candidate obstacle shape derived from it */
`timescale 1ns/100ps
`default_nettype none

module obstacle_generator #(
    parameter logic [31:0] lfsr_seed = 32'h1
) (
    input  wire                      clk,
    input  wire                      rst_n,
    output map_pkg::obstacle_shape_t shape
);
    import map_pkg::*;

    // feedback mask for taps 32, 22, 2, 1 in right-shift form
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    localparam int width_span  = max_width - min_width + 1;
    localparam int height_span = max_height - min_height + 1;
    localparam int gap_span    = max_gap - min_gap + 1;

    logic [31:0] lfsr;

    // ============================================================
    // LFSR steps every frame whatever the mode
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= lfsr_seed;
        end else if (lfsr[0]) begin
            lfsr <= {1'b0, lfsr[31:1]} ^ lfsr_taps;
        end else begin
            lfsr <= {1'b0, lfsr[31:1]};
        end
    end

    // ============================================================
    // shape from the current state
    // ============================================================
    always_comb begin
        int h;
        int free_span;

        h = min_height + int'(lfsr[15:8]) % height_span;

        // room left for the top edge so the bottom stays in the play area
        free_span = lower_bound - h - upper_bound + 1;

        shape.width  = 7'(min_width + int'(lfsr[7:0]) % width_span);
        shape.height = 8'(h);
        shape.y      = 9'(upper_bound + int'(lfsr[31:23]) % free_span);
        shape.gap    = 8'(min_gap + int'(lfsr[23:16]) % gap_span);
    end

endmodule

`default_nettype wire

// File: source/obstacle_field.sv
/* obstacle slot table: scrolling, lowest-free-slot spawning,
   deletion off the left edge and the saturating score */
`timescale 1ns/100ps
`default_nettype none

module obstacle_field #(
    parameter int num_obstacles = 10,
    parameter int score_limit   = 9999
) (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire map_pkg::game_mode_t                     mode,
    input  wire map_pkg::obstacle_shape_t                shape,
    output map_pkg::obstacle_t [num_obstacles-1:0]       slots,
    output logic               [13:0]                    score
);
    import map_pkg::*;

    // parking position for idle slots well right of the screen
    localparam int park_x = screen_width + 100;

    obstacle_t   [num_obstacles-1:0] slots_next;
    logic signed [11:0]              spawn_x;
    logic signed [11:0]              spawn_x_next;
    logic        [13:0]              score_next;

    // ============================================================
    // next state
    // ============================================================
    always_comb begin
        int   deleted;
        logic spawned;

        slots_next   = slots;
        spawn_x_next = spawn_x;
        score_next   = score;
        deleted      = 0;
        spawned      = 1'b0;

        case (mode)
            mode_idle: begin
                for (int i = 0; i < num_obstacles; i++) begin
                    slots_next[i].active = 1'b0;
                    slots_next[i].x      = 12'(park_x);
                end
                spawn_x_next = 12'(spawn_reload);
                score_next   = '0;
            end

            mode_run: begin
                // scroll and retire what has left the screen
                for (int i = 0; i < num_obstacles; i++) begin
                    if (slots[i].active) begin
                        slots_next[i].x = slots[i].x - 12'(scroll_speed);
                        if (slots[i].x + $signed({5'b0, slots[i].width}) < delete_margin) begin
                            slots_next[i].active = 1'b0;
                            deleted++;
                        end
                    end
                end

                spawn_x_next = spawn_x - 12'(scroll_speed);

                // lowest free slot takes the current shape
                if (spawn_x <= screen_width) begin
                    for (int i = 0; i < num_obstacles; i++) begin
                        if (!slots[i].active && !spawned) begin
                            spawned              = 1'b1;
                            slots_next[i].active = 1'b1;
                            slots_next[i].x      = 12'(screen_width);
                            slots_next[i].y      = shape.y;
                            slots_next[i].width  = shape.width;
                            slots_next[i].height = shape.height;
                            spawn_x_next         = 12'(screen_width + int'(shape.gap));
                        end
                    end
                end

                if (int'(score) + deleted > score_limit) begin
                    score_next = 14'(score_limit);
                end else begin
                    score_next = 14'(int'(score) + deleted);
                end
            end

            // pause holds everything
            default: ;
        endcase
    end

    // ============================================================
    // state registers
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_obstacles; i++) begin
                slots[i] <= '{active: 1'b0, x: 12'(park_x), y: '0, width: '0, height: '0};
            end
            spawn_x <= 12'(spawn_reload);
            score   <= '0;
        end else begin
            slots   <= slots_next;
            spawn_x <= spawn_x_next;
            score   <= score_next;
        end
    end

endmodule

`default_nettype wire

// File: source/screen_clip.sv
/* registered screen boxes per slot, off-screen sentinel when not visible */
`timescale 1ns/100ps
`default_nettype none

module screen_clip #(
    parameter int num_obstacles = 10
) (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire map_pkg::obstacle_t [num_obstacles-1:0]  slots,
    output map_pkg::screen_box_t    [num_obstacles-1:0]  boxes
);
    import map_pkg::*;

    localparam screen_box_t sentinel = '{
        x_left:  10'(offscreen_x),
        x_right: 10'(offscreen_x),
        y_up:    9'(offscreen_y),
        y_down:  9'(offscreen_y)
    };

    // ============================================================
    // one registered box per slot
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boxes <= {num_obstacles{sentinel}};
        end else begin
            for (int i = 0; i < num_obstacles; i++) begin
                // left edge must be on screen
                if (slots[i].active && slots[i].x >= 0 && slots[i].x < screen_width) begin
                    boxes[i].x_left  <= 10'(slots[i].x);
                    boxes[i].x_right <= 10'(slots[i].x + $signed({5'b0, slots[i].width}));
                    boxes[i].y_up    <= slots[i].y;
                    boxes[i].y_down  <= 9'(slots[i].y + slots[i].height);
                end else begin
                    boxes[i] <= sentinel;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/map.sv
/* obstacle map top: generator, slot table and clipping stage in a chain */
`timescale 1ns/100ps
`default_nettype none

module map #(
    parameter int          num_obstacles = 10,
    parameter int          score_limit   = 9999,
    parameter logic [31:0] lfsr_seed     = 32'h1
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire map_pkg::game_mode_t                      mode,
    output map_pkg::screen_box_t [num_obstacles-1:0]      boxes,
    output logic                 [13:0]                   score
);
    import map_pkg::*;

    obstacle_shape_t                 shape;
    obstacle_t [num_obstacles-1:0]   slots;

    obstacle_generator #(
        .lfsr_seed (lfsr_seed)
    ) u_generator (
        .clk   (clk),
        .rst_n (rst_n),
        .shape (shape)
    );

    obstacle_field #(
        .num_obstacles (num_obstacles),
        .score_limit   (score_limit)
    ) u_field (
        .clk   (clk),
        .rst_n (rst_n),
        .mode  (mode),
        .shape (shape),
        .slots (slots),
        .score (score)
    );

    // boxes trail the slot table by one frame
    screen_clip #(
        .num_obstacles (num_obstacles)
    ) u_clip (
        .clk   (clk),
        .rst_n (rst_n),
        .slots (slots),
        .boxes (boxes)
    );

endmodule

`default_nettype wire

// File: test/map_assertions.sv
/* concurrent checks on the obstacle map outputs, bound to the top level */
`timescale 1ns/100ps
`default_nettype none

module map_assertions #(
    parameter int num_obstacles = 10,
    parameter int score_limit   = 9999
) (
    input wire                                            clk,
    input wire                                            rst_n,
    input wire map_pkg::game_mode_t                       mode,
    input wire map_pkg::screen_box_t [num_obstacles-1:0]  boxes,
    input wire                       [13:0]               score
);
    import map_pkg::*;

    // sentinel, or a box of legal width whose top is inside the play area
    function automatic logic box_ok(input screen_box_t b);
        int w;
        w = int'(b.x_right) - int'(b.x_left);
        if (b.x_left == 10'(offscreen_x) && b.x_right == 10'(offscreen_x) &&
            b.y_up == 9'(offscreen_y) && b.y_down == 9'(offscreen_y)) begin
            return 1'b1;
        end
        return w >= min_width && w <= max_width && int'(b.y_up) >= upper_bound;
    endfunction

    score_capped: assert property (@(posedge clk) disable iff (!rst_n)
        int'(score) <= score_limit)
        else $error("score above its limit");

    // score updated under run may only grow
    score_rising: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == mode_run) |=> (score >= $past(score)))
        else $error("score dropped while running");

    for (genvar i = 0; i < num_obstacles; i++) begin : g_box
        box_shape: assert property (@(posedge clk) disable iff (!rst_n) box_ok(boxes[i]))
            else $error("box %0d is neither the sentinel nor a legal obstacle", i);
    end

endmodule

`default_nettype wire

// File: test/map_tb.sv
/* obstacle map testbench: stimulus file reader, per-frame box model,
   score and box compare tasks, watchdog */
`timescale 1ns/100ps
`default_nettype none

module map_tb;
    import map_pkg::*;

    localparam int num_obstacles = 10;
    localparam int score_limit   = 3;
    localparam int period_ns     = 20;
    // spawn on run frame 21, one frame to scroll in, one frame in the clip stage
    localparam int first_visible = (spawn_reload - screen_width) / scroll_speed + 3;
    localparam screen_box_t sentinel = '{10'(offscreen_x), 10'(offscreen_x),
                                         9'(offscreen_y), 9'(offscreen_y)};

    logic                            clk;
    logic                            rst_n;
    game_mode_t                      mode;
    screen_box_t [num_obstacles-1:0] boxes;
    logic        [13:0]              score;

    screen_box_t [num_obstacles-1:0] prev_boxes;
    logic        [13:0]              prev_score;
    game_mode_t                      mode_now;
    game_mode_t                      mode_before;
    int     step_mode[$];
    int     step_frames[$];
    int     step_check[$];
    int     step_score[$];
    int     error_count = 0;
    int     run_count = 0;
    bit     box_seen = 1'b0;
    bit     paused = 1'b0;
    longint watchdog_ns = 0;

    map #(
        .num_obstacles (num_obstacles),
        .score_limit   (score_limit)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .mode  (mode),
        .boxes (boxes),
        .score (score)
    );

    bind map map_assertions #(
        .num_obstacles (num_obstacles),
        .score_limit   (score_limit)
    ) u_assertions (
        .clk   (clk),
        .rst_n (rst_n),
        .mode  (mode),
        .boxes (boxes),
        .score (score)
    );

    initial clk = 1'b0;
    always #(period_ns / 2) clk = ~clk;

    // ============================================================
    // compare tasks and helpers
    // ============================================================
    task automatic check_box(input int slot, input screen_box_t got, input screen_box_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: boxes[%0d] is %h, expected %h", slot, got, exp);
        end
    endtask

    task automatic check_score(input logic [13:0] got, input logic [13:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: score is %h, expected %h", got, exp);
        end
    endtask

    task automatic flag_failure(input string text);
        error_count++;
        $display("%s", text);
    endtask

    function automatic bit on_screen(input screen_box_t b);
        return b != sentinel;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    m;
        int    f;
        int    c;
        int    s;
        string line;
        fd = $fopen("test/map_stimulus.txt", "r");
        if (fd == 0) begin
            flag_failure("could not open the stimulus file test/map_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    // comment and blank lines do not parse as four numbers
                    n = $sscanf(line, "%d %d %d %d", m, f, c, s);
                    if (n == 4) begin
                        step_mode.push_back(m);
                        step_frames.push_back(f);
                        step_check.push_back(c);
                        step_score.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ============================================================
    // per-frame model of boxes and score
    // ============================================================
    task automatic check_frame();
        screen_box_t exp;
        int          w;
        int          h;
        for (int i = 0; i < num_obstacles; i++) begin
            if (on_screen(boxes[i])) begin
                w = int'(boxes[i].x_right) - int'(boxes[i].x_left);
                h = int'(boxes[i].y_down) - int'(boxes[i].y_up);
                if (w < min_width || w > max_width || h < min_height || h > max_height ||
                    int'(boxes[i].y_up) < upper_bound || int'(boxes[i].y_down) > lower_bound)
                    flag_failure($sformatf("boxes[%0d] is outside the obstacle ranges", i));
            end
            // boxes trail the slots, so the mode one edge back decides
            case (mode_before)
                mode_idle: check_box(i, boxes[i], sentinel);
                mode_run: begin
                    if (on_screen(prev_boxes[i]) && on_screen(boxes[i])) begin
                        exp         = prev_boxes[i];
                        exp.x_left  = prev_boxes[i].x_left - 10'(scroll_speed);
                        exp.x_right = prev_boxes[i].x_right - 10'(scroll_speed);
                        check_box(i, boxes[i], exp);
                    end else if (on_screen(boxes[i])) begin
                        // a new box enters one scroll step left of the right edge
                        exp        = boxes[i];
                        exp.x_left = 10'(screen_width - scroll_speed);
                        check_box(i, boxes[i], exp);
                        if (mode_now != mode_idle) begin
                            if (!box_seen && !paused && (i != 0 || run_count != first_visible))
                                flag_failure($sformatf("first obstacle showed in slot %0d %s %0d",
                                             i, "after run frames:", run_count));
                            box_seen = 1'b1;
                        end
                    end else if (on_screen(prev_boxes[i]) &&
                                 prev_boxes[i].x_left >= 10'(scroll_speed)) begin
                        flag_failure($sformatf("boxes[%0d] vanished while on screen", i));
                    end
                end
                default: check_box(i, boxes[i], prev_boxes[i]);
            endcase
        end
        if (mode_now == mode_run && !paused && !box_seen && run_count == first_visible)
            flag_failure($sformatf("no obstacle was visible after %0d run frames", run_count));
        case (mode_now)
            mode_idle: check_score(score, '0);
            mode_run: begin
                if (score < prev_score || int'(score) > score_limit)
                    flag_failure($sformatf("score went from %0d to %0d while running",
                                 prev_score, score));
            end
            default: check_score(score, prev_score);
        endcase
    endtask

    task automatic run_step(input int s);
        int errors_before;
        errors_before = error_count;
        mode = game_mode_t'(2'(step_mode[s]));
        repeat (step_frames[s]) begin
            @(posedge clk);
            @(negedge clk);
            mode_before = mode_now;
            mode_now    = mode;
            if (mode_now == mode_idle) begin
                run_count = 0;
                box_seen  = 1'b0;
                paused    = 1'b0;
            end else if (mode_now == mode_run) begin
                run_count++;
            end else begin
                paused = 1'b1;
            end
            check_frame();
            prev_boxes = boxes;
            prev_score = score;
        end
        if (step_check[s] != 0)
            check_score(score, 14'(step_score[s]));
        $display("step %0d: mode %0d for %0d frames, score %0d, %0d errors", s,
                 step_mode[s], step_frames[s], score, error_count - errors_before);
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        mode        = mode_idle;
        rst_n       = 1'b0;
        mode_now    = mode_idle;
        mode_before = mode_idle;
        load_stimulus();
        if (step_mode.size() == 0)
            flag_failure("the stimulus file holds no steps");
        for (int s = 0; s < step_mode.size(); s++)
            watchdog_ns += longint'(step_frames[s]) * period_ns;
        watchdog_ns += 5 * period_ns + 1000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_obstacles; i++)
            check_box(i, boxes[i], sentinel);
        check_score(score, '0);
        $display("reset: %0d errors", error_count);
        prev_boxes = boxes;
        prev_score = score;
        for (int s = 0; s < step_mode.size(); s++)
            run_step(s);
        $display("%0d steps run, %0d errors", step_mode.size(), error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired before the stimulus finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: map.f
source/map_pkg.sv
source/obstacle_generator.sv
source/obstacle_field.sv
source/screen_clip.sv
source/map.sv
test/map_assertions.sv
test/map_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the obstacle map testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module map_tb -f map.f -Mdir obj_dir -o map_sim

./obj_dir/map_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// File: test/map_stimulus.txt
# columns: mode (0 idle, 1 run, 2 or 3 pause), frames, check flag, expected score
# a check flag of 0 marks a step whose score is not compared
0 3 1 0
1 20 1 0
1 3 1 0
1 150 1 0
2 10 1 0
1 30 1 0
1 40 0 0
3 8 0 0
1 200 1 3
1 100 1 3
0 1 1 0
0 2 1 0
1 30 1 0
2 5 1 0
0 2 1 0
